//--- src/mpmc_settings.svh
`ifndef MPMC_SETTINGS_SVH
`define MPMC_SETTINGS_SVH

// ==================================================
// Controller sizing
// ==================================================

// Number of client ports sharing the request path
`define MPMC_NUM_PORTS 4

// Request FIFO entries
// Kept below the port count so that the arbiter sees back-pressure
`define MPMC_FIFO_DEPTH 2

// Cycles spent in the access state before the ready strobe
`define MPMC_ACCESS_CYCLES 3

// Words in the internal memory array, one per address value
`define MPMC_MEM_WORDS 256

`endif

//--- src/mpmc_bus_pkg.sv
package mpmc_bus_pkg;

	// ==================================================
	// Client side widths
	// ==================================================

	// Transaction id chosen by the client and echoed back with the acknowledge
	typedef logic [7:0] tranid_t;

	// Word address into the memory array
	typedef logic [7:0] addr_t;

	// One data word, for both write data and read data
	typedef logic [31:0] data_t;

	// ==================================================
	// Port request
	// ==================================================

	// Everything a client hands over with a single request strobe
	// Field order puts the write flag at the top bit
	typedef struct packed {
		// High for a write, low for a read
		logic wr;
		// Target word
		addr_t addr;
		// Only meaningful for writes
		data_t wdata;
		// Returned unchanged on tid when the request completes
		tranid_t tid;
	} port_req_t;

endpackage

//--- src/mpmc_ctrl_pkg.sv
package mpmc_ctrl_pkg;

`include "mpmc_settings.svh"

	// ==================================================
	// Controller internal types
	// ==================================================

	// Index of a client port, wide enough for the configured port count
	typedef logic [$clog2(`MPMC_NUM_PORTS)-1:0] port_idx_t;

	// One slot of the request FIFO
	// The port index travels with the request so the reply finds its way back
	typedef struct packed {
		port_idx_t port;
		mpmc_bus_pkg::port_req_t req;
	} fifo_entry_t;

	// Memory sequencer states
	// Idle waits for an entry, access counts the delay, respond strobes rdy
	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_respond
	} seq_state_t;

endpackage

//--- src/mpmc_port_arbiter.sv
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_port_arbiter (
	input logic clk,
	input logic rst,
	input logic [`MPMC_NUM_PORTS-1:0] req_stb,
	input mpmc_bus_pkg::port_req_t req [`MPMC_NUM_PORTS],
	input logic [`MPMC_NUM_PORTS-1:0] ack,
	input logic full,
	output logic push,
	output mpmc_ctrl_pkg::fifo_entry_t push_entry,
	output logic [`MPMC_NUM_PORTS-1:0] busy
);

	import mpmc_bus_pkg::*;
	import mpmc_ctrl_pkg::*;

	// One held request per port, waiting for a FIFO slot
	port_req_t pend [`MPMC_NUM_PORTS];
	logic [`MPMC_NUM_PORTS-1:0] pend_vld;

	// Port that won the last grant, the search starts just after it
	port_idx_t last_grant;
	port_idx_t grant_idx;
	logic grant_vld;

	// ==================================================
	// Round-robin selection
	// ==================================================

	always_comb begin
		int unsigned cand;
		grant_vld = 1'b0;
		grant_idx = last_grant;
		// Walk once around the ring starting after the last winner
		for (int i = 1; i <= `MPMC_NUM_PORTS; i++) begin
			cand = (int'(last_grant) + i) % `MPMC_NUM_PORTS;
			if (!grant_vld && pend_vld[cand]) begin
				grant_vld = 1'b1;
				grant_idx = port_idx_t'(cand);
			end
		end
	end

	// A full FIFO holds everything back and the requests stay pending
	assign push = grant_vld && !full;
	assign push_entry = '{port: grant_idx, req: pend[grant_idx]};

	// ==================================================
	// Per-port state
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_vld <= '0;
			busy <= '0;
			// Start just before port 0 so that port 0 wins the first tie
			last_grant <= port_idx_t'(`MPMC_NUM_PORTS - 1);
		end else begin
			for (int p = 0; p < `MPMC_NUM_PORTS; p++) begin
				// Clients only strobe while not busy, the check guards the held request
				if (req_stb[p] && !busy[p]) begin
					pend_vld[p] <= 1'b1;
					busy[p] <= 1'b1;
				end
				if (push && (grant_idx == port_idx_t'(p)))
					pend_vld[p] <= 1'b0;
				// Busy covers the whole trip through FIFO, sequencer and latch
				if (ack[p])
					busy[p] <= 1'b0;
			end
			if (push)
				last_grant <= grant_idx;
		end
	end

	// Request payload, captured on the strobe and read out at grant time
	always_ff @(posedge clk) begin
		for (int p = 0; p < `MPMC_NUM_PORTS; p++) begin
			if (req_stb[p] && !busy[p])
				pend[p] <= req[p];
		end
	end

endmodule

//--- src/mpmc_req_fifo.sv
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_req_fifo (
	input logic clk,
	input logic rst,
	input logic push,
	input mpmc_ctrl_pkg::fifo_entry_t push_entry,
	input logic pop,
	output mpmc_ctrl_pkg::fifo_entry_t pop_entry,
	output logic full,
	output logic empty
);

	import mpmc_ctrl_pkg::*;

	// A single-entry FIFO still needs one pointer bit
	localparam int PTR_W = (`MPMC_FIFO_DEPTH > 1) ? $clog2(`MPMC_FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(`MPMC_FIFO_DEPTH + 1);

	fifo_entry_t mem [`MPMC_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Requests that would overflow or underflow are ignored
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == CNT_W'(`MPMC_FIFO_DEPTH));
	assign empty = (count == '0);

	// Head entry is read straight from the array
	assign pop_entry = mem[rd_ptr];

	// ==================================================
	// Pointers and fill count
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(`MPMC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(`MPMC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous push and pop leave the count unchanged
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage, written at the tail
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

endmodule

//--- src/mpmc_mem_sequencer.sv
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_mem_sequencer (
	input logic clk,
	input logic rst,
	input logic empty,
	input mpmc_ctrl_pkg::fifo_entry_t pop_entry,
	output logic pop,
	output logic rdy,
	output mpmc_ctrl_pkg::fifo_entry_t served_entry,
	output mpmc_bus_pkg::data_t rd_data
);

	import mpmc_bus_pkg::*;
	import mpmc_ctrl_pkg::*;

	localparam int CNT_W = $clog2(`MPMC_ACCESS_CYCLES + 1);

	seq_state_t state;
	logic [CNT_W-1:0] cnt;

	// Entry being served, taken from the FIFO head on pop
	fifo_entry_t cur;

	// The memory array itself
	data_t mem [`MPMC_MEM_WORDS];

	// Last cycle of the access delay, the array is touched on this edge
	logic access_done;

	assign access_done = (state == st_access) && (cnt == '0);

	// Taking an entry is the only way out of idle
	assign pop = (state == st_idle) && !empty;

	// The respond state lasts one cycle, so rdy is a single-cycle strobe
	assign rdy = (state == st_respond);
	assign served_entry = cur;

	// ==================================================
	// Control FSM
	// ==================================================

	// Timeline for one entry
	// pop in idle, ACCESS_CYCLES in access, then one cycle of rdy in respond
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (!empty) begin
						state <= st_access;
						cnt <= CNT_W'(`MPMC_ACCESS_CYCLES - 1);
					end
				end
				st_access: begin
					if (cnt == '0)
						state <= st_respond;
					else
						cnt <= cnt - 1'b1;
				end
				st_respond: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// ==================================================
	// Memory access
	// ==================================================

	always_ff @(posedge clk) begin
		if (pop)
			cur <= pop_entry;
		if (access_done) begin
			// A write also returns its own word on rd_data
			if (cur.req.wr) begin
				mem[cur.req.addr] <= cur.req.wdata;
				rd_data <= cur.req.wdata;
			end else begin
				rd_data <= mem[cur.req.addr];
			end
		end
	end

endmodule

//--- src/mpmc_rd_return_latch.sv
`timescale 1ns/1ps

module mpmc_rd_return_latch #(
	parameter int PORT_ID = 0
) (
	input logic clk,
	input logic rst,
	input logic rdy,
	input mpmc_ctrl_pkg::fifo_entry_t served_entry,
	input mpmc_bus_pkg::data_t rd_data,
	output logic ack,
	output mpmc_bus_pkg::tranid_t tid,
	output mpmc_bus_pkg::data_t data
);

	import mpmc_ctrl_pkg::*;

	// The broadcast reaches every port, only the owner takes it
	logic hit;

	assign hit = rdy && (served_entry.port == port_idx_t'(PORT_ID));

	// Ack follows rdy by one edge, tid and data hold until the next hit
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			tid <= '0;
			data <= '0;
		end else begin
			ack <= hit;
			if (hit) begin
				tid <= served_entry.req.tid;
				data <= rd_data;
			end
		end
	end

endmodule

//--- src/mpmc_top.sv
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_top (
	input logic clk,
	input logic rst,
	input logic [`MPMC_NUM_PORTS-1:0] req_stb,
	input mpmc_bus_pkg::port_req_t req [`MPMC_NUM_PORTS],
	output logic [`MPMC_NUM_PORTS-1:0] busy,
	output logic [`MPMC_NUM_PORTS-1:0] ack,
	output mpmc_bus_pkg::tranid_t tid [`MPMC_NUM_PORTS],
	output mpmc_bus_pkg::data_t rd_data [`MPMC_NUM_PORTS]
);

	import mpmc_bus_pkg::*;
	import mpmc_ctrl_pkg::*;

	// Arbiter to FIFO
	logic push;
	fifo_entry_t push_entry;
	logic full;

	// FIFO to sequencer
	logic pop;
	logic empty;
	fifo_entry_t pop_entry;

	// Sequencer broadcast to all return latches
	logic rdy;
	fifo_entry_t served_entry;
	data_t seq_rd_data;

	// ==================================================
	// Shared request path
	// ==================================================

	mpmc_port_arbiter arbiter_i (
		.clk(clk),
		.rst(rst),
		.req_stb(req_stb),
		.req(req),
		.ack(ack),
		.full(full),
		.push(push),
		.push_entry(push_entry),
		.busy(busy)
	);

	mpmc_req_fifo fifo_i (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_entry(push_entry),
		.pop(pop),
		.pop_entry(pop_entry),
		.full(full),
		.empty(empty)
	);

	mpmc_mem_sequencer sequencer_i (
		.clk(clk),
		.rst(rst),
		.empty(empty),
		.pop_entry(pop_entry),
		.pop(pop),
		.rdy(rdy),
		.served_entry(served_entry),
		.rd_data(seq_rd_data)
	);

	// ==================================================
	// Per-port return
	// ==================================================

	// Every latch sees the same broadcast and filters on its own index
	for (genvar g = 0; g < `MPMC_NUM_PORTS; g++) begin : gen_latch
		mpmc_rd_return_latch #(
			.PORT_ID(g)
		) latch_i (
			.clk(clk),
			.rst(rst),
			.rdy(rdy),
			.served_entry(served_entry),
			.rd_data(seq_rd_data),
			.ack(ack[g]),
			.tid(tid[g]),
			.data(rd_data[g])
		);
	end

endmodule

//--- testbench/mpmc_assertions.sv
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_assertions (
	input logic clk,
	input logic rst,
	input logic rdy,
	input logic push,
	input logic full,
	input logic [`MPMC_NUM_PORTS-1:0] ack
);

	// The respond state lasts one cycle, then the sequencer returns to idle
	a_rdy_single: assert property (@(posedge clk) disable iff (rst) rdy |=> !rdy)
		else $error("rdy was high on two consecutive cycles");

	// Back-pressure keeps the arbiter from writing into a full FIFO
	a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
		else $error("push was asserted while the FIFO was full");

	// Every acknowledge comes from the broadcast one cycle earlier
	a_ack_after_rdy: assert property (@(posedge clk) disable iff (rst) (|ack) |-> $past(rdy))
		else $error("ack rose without rdy on the cycle before");

endmodule

bind mpmc_top mpmc_assertions assertions_i (
	.clk(clk),
	.rst(rst),
	.rdy(rdy),
	.push(push),
	.full(full),
	.ack(ack)
);

//--- testbench/mpmc_tb.sv
`timescale 1ns/1ps

`include "mpmc_settings.svh"

module mpmc_tb;

	import mpmc_bus_pkg::*;

	localparam int NP = `MPMC_NUM_PORTS;
	// Longest wait for one port's acknowledge, in clock cycles
	// Four queued requests need well under half of this
	localparam int ACK_TIMEOUT = 64;

	logic clk;
	logic rst;
	logic [NP-1:0] req_stb;
	port_req_t req [NP];
	logic [NP-1:0] busy;
	logic [NP-1:0] ack;
	tranid_t tid [NP];
	data_t rd_data [NP];

	// Request lines as loaded from the stimulus file, in file order
	int q_grp [$];
	int q_port [$];
	port_req_t q_req [$];
	data_t q_exp [$];

	// Scoreboard per port
	// active marks a request that was strobed and not yet acknowledged
	logic [NP-1:0] active;
	tranid_t want_tid [NP];
	data_t want_data [NP];
	// Values of the last acknowledge, which the outputs must keep
	tranid_t last_tid [NP];
	data_t last_data [NP];

	integer seed;

	mpmc_top mpmc_top_i (
		.clk(clk),
		.rst(rst),
		.req_stb(req_stb),
		.req(req),
		.busy(busy),
		.ack(ack),
		.tid(tid),
		.rd_data(rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ==================================================
	// Checks
	// ==================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_tid(input int p, input tranid_t got, input tranid_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR tid[%0d] got 0x%h expected 0x%h", p, got, exp));
	endtask

	task automatic check_data(input int p, input data_t got, input data_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR rd_data[%0d] got 0x%h expected 0x%h", p, got, exp));
	endtask

	task automatic check_flag(input string name, input int p, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s[%0d] got 0x%h expected 0x%h", name, p, got, exp));
	endtask

	// ==================================================
	// Stimulus file
	// ==================================================

	task automatic load_stimulus();
		int fd;
		int n;
		string line;
		int f_grp;
		int f_port;
		logic f_wr;
		addr_t f_addr;
		data_t f_wdata;
		tranid_t f_tid;
		data_t f_exp;
		port_req_t r;
		fd = $fopen("testbench/mpmc_stimulus.txt", "r");
		if (fd == 0)
			abort_run("Could not open the stimulus file testbench/mpmc_stimulus.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// Blank lines and lines starting with a hash carry no request
			if (n > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %h %h %h %h %h",
					f_grp, f_port, f_wr, f_addr, f_wdata, f_tid, f_exp);
				if (n != 7)
					abort_run($sformatf("Malformed stimulus line: %s", line));
				if (f_port < 0 || f_port >= NP)
					abort_run($sformatf("Stimulus line names a port that does not exist: %s", line));
				r.wr = f_wr;
				r.addr = f_addr;
				r.wdata = f_wdata;
				r.tid = f_tid;
				q_grp.push_back(f_grp);
				q_port.push_back(f_port);
				q_req.push_back(r);
				q_exp.push_back(f_exp);
			end
		end
		$fclose(fd);
		if (q_grp.size() == 0)
			abort_run("The stimulus file holds no request lines");
	endtask

	// ==================================================
	// Driving and watching the ports
	// ==================================================

	// One clock cycle, sampled 1 ns after the edge where all outputs have settled
	// Every port is checked each cycle, so acks of other ports are never missed
	task automatic watch_cycle();
		@(posedge clk);
		#1;
		req_stb = '0;
		for (int p = 0; p < NP; p++) begin
			if (ack[p]) begin
				// A second cycle of ack lands here too, since active is already clear
				if (!active[p])
					abort_run($sformatf("Port %0d acknowledged with no request outstanding", p));
				check_flag("busy", p, busy[p], 1'b1);
				check_tid(p, tid[p], want_tid[p]);
				check_data(p, rd_data[p], want_data[p]);
				active[p] = 1'b0;
				last_tid[p] = want_tid[p];
				last_data[p] = want_data[p];
			end else begin
				// Busy clears on the cycle after ack, outputs hold meanwhile
				check_flag("busy", p, busy[p], active[p]);
				check_tid(p, tid[p], last_tid[p]);
				check_data(p, rd_data[p], last_data[p]);
			end
		end
	endtask

	// Strobes every line of one group in the same cycle
	task automatic strobe_group(input int first, output int next);
		int g;
		int i;
		int p;
		g = q_grp[first];
		i = first;
		while (i < q_grp.size() && q_grp[i] == g) begin
			p = q_port[i];
			if (active[p])
				abort_run($sformatf("Stimulus group %0d uses port %0d twice", g, p));
			req[p] = q_req[i];
			req_stb[p] = 1'b1;
			active[p] = 1'b1;
			want_tid[p] = q_req[i].tid;
			want_data[p] = q_exp[i];
			i++;
		end
		next = i;
	endtask

	task automatic wait_ack(input int p);
		int cycles;
		cycles = 0;
		while (active[p]) begin
			if (cycles == ACK_TIMEOUT)
				abort_run($sformatf("Timeout waiting for the acknowledge on port %0d", p));
			watch_cycle();
			cycles++;
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		int idx;
		int nxt;
		int gap;
		seed = 32'h1cdbeebf;
		rst = 1'b1;
		req_stb = '0;
		active = '0;
		for (int p = 0; p < NP; p++) begin
			req[p] = '0;
			want_tid[p] = '0;
			want_data[p] = '0;
			last_tid[p] = '0;
			last_data[p] = '0;
		end
		load_stimulus();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		// Reset state, before the first request
		for (int p = 0; p < NP; p++) begin
			check_flag("busy", p, busy[p], 1'b0);
			check_flag("ack", p, ack[p], 1'b0);
			check_tid(p, tid[p], '0);
			check_data(p, rd_data[p], '0);
		end
		idx = 0;
		while (idx < q_grp.size()) begin
			strobe_group(idx, nxt);
			idx = nxt;
			// Ports that were not strobed return at once
			for (int p = 0; p < NP; p++)
				wait_ack(p);
			// Random idle gap, at least one cycle so busy can clear
			gap = 1 + ({$random(seed)} % 4);
			repeat (gap) watch_cycle();
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- testbench/mpmc_stimulus.txt
# group port wr addr wdata tid expected
# group and port in decimal, the rest in hex; lines of one group strobe in one cycle
0 0 1 10 deadbeef 01 deadbeef
1 0 0 10 00000000 02 deadbeef
2 0 1 20 11111111 10 11111111
2 1 1 21 22222222 11 22222222
2 2 1 22 33333333 12 33333333
2 3 1 23 44444444 13 44444444
3 0 0 23 00000000 20 44444444
3 1 0 22 00000000 21 33333333
3 2 0 21 00000000 22 22222222
3 3 0 20 00000000 23 11111111
4 2 1 40 a5a5a5a5 30 a5a5a5a5
5 2 0 40 00000000 31 a5a5a5a5
6 0 0 10 00000000 40 deadbeef
6 1 1 50 cafef00d 41 cafef00d
6 3 0 40 00000000 42 a5a5a5a5
7 1 0 50 00000000 50 cafef00d
7 3 1 ff 0badc0de 51 0badc0de
8 0 0 ff 00000000 60 0badc0de
8 1 0 50 00000000 61 cafef00d
8 2 0 20 00000000 62 11111111
8 3 0 10 00000000 63 deadbeef
9 3 1 10 12345678 70 12345678
10 1 0 10 00000000 71 12345678

//--- verilog.f
+incdir+src
src/mpmc_bus_pkg.sv
src/mpmc_ctrl_pkg.sv
src/mpmc_port_arbiter.sv
src/mpmc_req_fifo.sv
src/mpmc_mem_sequencer.sv
src/mpmc_rd_return_latch.sv
src/mpmc_top.sv
testbench/mpmc_assertions.sv
testbench/mpmc_tb.sv

//--- Makefile
TOP = mpmc_tb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f src/*.sv src/*.svh testbench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
